// ==== rtl/scan_pkg.sv ====
/*
 * Shared video, audio, control word and OSD request types
 * Color and button widths, OSD palette, LED hold and off pattern
 */
`default_nettype none

package scan_pkg;

    localparam int COLOR_W = 8;
    localparam int BTN_W = 6;
    localparam int RESYNC_HOLD_W = 24;
    localparam logic [2:0] LED_OFF_PATTERN = 3'b001;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } pixel_t;

    typedef struct packed {
        pixel_t pix;
        logic   hsync;
        logic   vsync;
        logic   de;
    } video_t;

    // Bit 15 down to bit 0
    typedef struct packed {
        logic       hdmirx_spdif;
        logic       framelock;
        logic [1:0] rsvd_13_12;
        logic       audmux_sel;
        logic       rsvd_10;
        logic       isl_vsync_pol;
        logic       isl_hsync_pol;
        logic       capture_sel;
        logic [5:0] rsvd_6_1;
        logic       poweron;
    } ctrl_t;

    typedef struct packed {
        logic       enable;
        logic [1:0] color;
    } osd_t;

    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } audio_t;

    localparam pixel_t OSD_PALETTE [4] = '{
        24'h000000,
        24'h0000FF,
        24'hFFFF00,
        24'hFFFFFF
    };

endpackage

`default_nettype wire

// ==== rtl/source_select.sv ====
/*
 * Input registers for the analog digitizer and HDMI receiver
 * Analog sync polarity normalization, capture select register
 * I2S and S/PDIF routing to the transmitter
 */
`timescale 1ns/1ns
`default_nettype none

module source_select (
    input  logic             CLK27_i,
    input  logic             po_reset_n,
    input  scan_pkg::ctrl_t  ctrl_i,
    input  scan_pkg::video_t isl_video_i,
    input  scan_pkg::video_t hdmi_video_i,
    input  scan_pkg::audio_t pcm_i2s_i,
    input  scan_pkg::audio_t hdmirx_i2s_i,
    input  logic             hdmirx_ap_i,
    input  logic             spdif_ext_i,
    output scan_pkg::video_t capt_video_o,
    output scan_pkg::audio_t hdmitx_i2s_o,
    output logic             hdmitx_spdif_o,
    output logic             audmux_o
);

    import scan_pkg::*;

    video_t isl_q;
    video_t hdmi_q1;
    video_t hdmi_q2;
    video_t isl_fixed;
    audio_t hdmirx_group;

    // Analog source gets one input register, HDMI gets two
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_q <= '0;
            hdmi_q1 <= '0;
            hdmi_q2 <= '0;
        end else begin
            isl_q <= isl_video_i;
            hdmi_q1 <= hdmi_video_i;
            hdmi_q2 <= hdmi_q1;
        end
    end

    // Syncs leave here active high regardless of digitizer polarity
    always_comb begin
        isl_fixed = isl_q;
        isl_fixed.hsync = isl_q.hsync ^ ctrl_i.isl_hsync_pol;
        isl_fixed.vsync = isl_q.vsync ^ ctrl_i.isl_vsync_pol;
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            capt_video_o <= '0;
        end else begin
            capt_video_o <= ctrl_i.capture_sel ? hdmi_q2 : isl_fixed;
        end
    end

    // Receiver audio packet pin doubles as the I2S data line
    always_comb begin
        hdmirx_group.bck = hdmirx_i2s_i.bck;
        hdmirx_group.ws = hdmirx_i2s_i.ws;
        hdmirx_group.data = hdmirx_ap_i;
    end

    assign hdmitx_i2s_o = ctrl_i.capture_sel ? hdmirx_group : pcm_i2s_i;
    assign hdmitx_spdif_o = ctrl_i.hdmirx_spdif ? hdmirx_ap_i : spdif_ext_i;
    assign audmux_o = ~ctrl_i.audmux_sel;

endmodule

`default_nettype wire

// ==== rtl/panel_sync.sv ====
/*
 * Button and IR receiver synchronizers
 * Controls word and expansion port drive
 */
`timescale 1ns/1ns
`default_nettype none

module panel_sync (
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,
    input  logic [scan_pkg::BTN_W-1:0] btn_i,
    input  logic                       ir_rx_i,
    output logic [31:0]                controls_o,
    output logic [5:0]                 ext_io_o,
    output logic                       ir_sync_o
);

    import scan_pkg::*;

    // IR line rides in the top bit next to the buttons
    logic [BTN_W:0] sync1_q;
    logic [BTN_W:0] sync2_q;
    logic [BTN_W-1:0] btn_sync;
    logic no_btn;

    // Buttons and IR idle high, so reset to ones
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sync1_q <= '1;
            sync2_q <= '1;
        end else begin
            sync1_q <= {ir_rx_i, btn_i};
            sync2_q <= sync1_q;
        end
    end

    assign btn_sync = sync2_q[BTN_W-1:0];
    assign ir_sync_o = sync2_q[BTN_W];

    assign controls_o = {{(16 - BTN_W){1'b0}}, btn_sync, 16'h0000};

    // Buttons are active low
    assign no_btn = &btn_sync;
    assign ext_io_o = {6{no_btn}};

endmodule

`default_nettype wire

// ==== rtl/osd_overlay.sv ====
/*
 * OSD palette substitution stage
 * Transmitter launch register
 */
`timescale 1ns/1ns
`default_nettype none

module osd_overlay (
    input  logic             CLK27_i,
    input  logic             po_reset_n,
    input  scan_pkg::video_t video_i,
    input  scan_pkg::osd_t   osd_i,
    output scan_pkg::video_t video_o
);

    import scan_pkg::*;

    video_t mix_q;
    pixel_t mix_pix;

    assign mix_pix = osd_i.enable ? OSD_PALETTE[osd_i.color] : video_i.pix;

    // Syncs and de are delayed along with the pixel
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_q <= '0;
        end else begin
            mix_q.pix <= mix_pix;
            mix_q.hsync <= video_i.hsync;
            mix_q.vsync <= video_i.vsync;
            mix_q.de <= video_i.de;
        end
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            video_o <= '0;
        end else begin
            video_o <= mix_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/status_led.sv ====
/*
 * Resync strobe synchronizer and rising edge detect
 * LED hold counter and status LED encoding
 */
`timescale 1ns/1ns
`default_nettype none

module status_led (
    input  logic            CLK27_i,
    input  logic            po_reset_n,
    input  scan_pkg::ctrl_t ctrl_i,
    input  logic            ir_sync_i,
    input  logic            resync_strobe_i,
    output logic [2:0]      led_o
);

    import scan_pkg::*;

    logic strobe_sync1_q;
    logic strobe_sync2_q;
    logic strobe_prev_q;
    logic strobe_rise_q;
    logic [RESYNC_HOLD_W-1:0] hold_ctr_q;
    logic hold_active;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1_q <= 1'b0;
            strobe_sync2_q <= 1'b0;
            strobe_prev_q <= 1'b0;
            strobe_rise_q <= 1'b0;
        end else begin
            strobe_sync1_q <= resync_strobe_i;
            strobe_sync2_q <= strobe_sync1_q;
            strobe_prev_q <= strobe_sync2_q;
            strobe_rise_q <= strobe_sync2_q & ~strobe_prev_q;
        end
    end

    // Retrigger reloads the full hold time
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_ctr_q <= '0;
        end else if (strobe_rise_q) begin
            hold_ctr_q <= '1;
        end else if (hold_active) begin
            hold_ctr_q <= hold_ctr_q - 1'b1;
        end
    end

    assign hold_active = |hold_ctr_q;

    // Blue, green, red; IR line idles high
    assign led_o = ctrl_i.poweron ? {ctrl_i.framelock, ~ir_sync_i, hold_active}
                                  : LED_OFF_PATTERN;

endmodule

`default_nettype wire

// ==== rtl/ossc_top.sv ====
/*
 * Scan converter video and panel path top level
 * Source select, OSD overlay, panel synchronizers, status LEDs
 */
`timescale 1ns/1ns
`default_nettype none

module ossc_top (
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,
    input  scan_pkg::ctrl_t            sys_ctrl_i,
    input  scan_pkg::video_t           isl_video_i,
    input  scan_pkg::video_t           hdmi_video_i,
    input  scan_pkg::audio_t           pcm_i2s_i,
    input  scan_pkg::audio_t           hdmirx_i2s_i,
    input  logic                       hdmirx_ap_i,
    input  logic                       spdif_ext_i,
    input  scan_pkg::osd_t             osd_i,
    input  logic                       resync_strobe_i,
    input  logic [scan_pkg::BTN_W-1:0] btn_i,
    input  logic                       ir_rx_i,
    output scan_pkg::video_t           hdmitx_video_o,
    output scan_pkg::audio_t           hdmitx_i2s_o,
    output logic                       hdmitx_spdif_o,
    output logic                       audmux_o,
    output logic [31:0]                controls_o,
    output logic [5:0]                 ext_io_o,
    output logic [2:0]                 led_o
);

    import scan_pkg::*;

    video_t capt_video;
    logic ir_sync;

    source_select u_source_select (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .ctrl_i         (sys_ctrl_i),
        .isl_video_i    (isl_video_i),
        .hdmi_video_i   (hdmi_video_i),
        .pcm_i2s_i      (pcm_i2s_i),
        .hdmirx_i2s_i   (hdmirx_i2s_i),
        .hdmirx_ap_i    (hdmirx_ap_i),
        .spdif_ext_i    (spdif_ext_i),
        .capt_video_o   (capt_video),
        .hdmitx_i2s_o   (hdmitx_i2s_o),
        .hdmitx_spdif_o (hdmitx_spdif_o),
        .audmux_o       (audmux_o)
    );

    panel_sync u_panel_sync (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .btn_i      (btn_i),
        .ir_rx_i    (ir_rx_i),
        .controls_o (controls_o),
        .ext_io_o   (ext_io_o),
        .ir_sync_o  (ir_sync)
    );

    osd_overlay u_osd_overlay (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .video_i    (capt_video),
        .osd_i      (osd_i),
        .video_o    (hdmitx_video_o)
    );

    status_led u_status_led (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .ctrl_i          (sys_ctrl_i),
        .ir_sync_i       (ir_sync),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o)
    );

endmodule

`default_nettype wire

// ==== tb/ossc_sva.sv ====
/*
 * Concurrent assertions bound to the top level
 * Reset state of de, powered off LED pattern, expansion port drive
 */
`timescale 1ns/1ns
`default_nettype none

module ossc_sva (
    input logic             CLK27_i,
    input logic             po_reset_n,
    input scan_pkg::ctrl_t  sys_ctrl_i,
    input scan_pkg::video_t hdmitx_video_o,
    input logic [5:0]       ext_io_o,
    input logic [2:0]       led_o
);

    import scan_pkg::*;

    // Video registers clear on reset, so de starts inactive
    de_after_reset: assert property (@(posedge CLK27_i)
        $rose(po_reset_n) |-> !hdmitx_video_o.de)
        else $error("de active in the first cycle after reset");

    led_powered_off: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        (!sys_ctrl_i.poweron && !$past(sys_ctrl_i.poweron)) |-> led_o == LED_OFF_PATTERN)
        else $error("LEDs differ from the off pattern while powered off");

    ext_io_uniform: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        ext_io_o == 6'h3F || ext_io_o == 6'h00)
        else $error("expansion port bits are not all equal");

endmodule

bind ossc_top ossc_sva i_sva (
    .CLK27_i        (CLK27_i),
    .po_reset_n     (po_reset_n),
    .sys_ctrl_i     (sys_ctrl_i),
    .hdmitx_video_o (hdmitx_video_o),
    .ext_io_o       (ext_io_o),
    .led_o          (led_o)
);

`default_nettype wire

// ==== tb/tb_ossc.sv ====
/*
 * Testbench for the scan converter top level
 * Case file stimulus, LCG driven audio and IR, LED model, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module tb_ossc;

    import scan_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 3;
    localparam int CASE_CYCLES = 8;
    localparam int NUM_CASES = 13;
    localparam int FIELDS = 8;
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CASES * CASE_CYCLES + 20) * CLK_PERIOD;

    logic clk27;
    logic po_reset_n;
    ctrl_t sys_ctrl;
    video_t isl_video;
    video_t hdmi_video;
    audio_t pcm_i2s;
    audio_t hdmirx_i2s;
    logic hdmirx_ap;
    logic spdif_ext;
    osd_t osd;
    logic resync_strobe;
    logic [BTN_W-1:0] btn;
    logic ir_rx;
    video_t hdmitx_video;
    audio_t hdmitx_i2s;
    logic hdmitx_spdif;
    logic audmux;
    logic [31:0] controls;
    logic [5:0] ext_io;
    logic [2:0] led;

    logic [31:0] case_mem [0:NUM_CASES*FIELDS-1];
    logic [31:0] lcg_state;
    logic hold_seen;
    int checks;
    int errors;

    ossc_top i_dut (
        .CLK27_i         (clk27),
        .po_reset_n      (po_reset_n),
        .sys_ctrl_i      (sys_ctrl),
        .isl_video_i     (isl_video),
        .hdmi_video_i    (hdmi_video),
        .pcm_i2s_i       (pcm_i2s),
        .hdmirx_i2s_i    (hdmirx_i2s),
        .hdmirx_ap_i     (hdmirx_ap),
        .spdif_ext_i     (spdif_ext),
        .osd_i           (osd),
        .resync_strobe_i (resync_strobe),
        .btn_i           (btn),
        .ir_rx_i         (ir_rx),
        .hdmitx_video_o  (hdmitx_video),
        .hdmitx_i2s_o    (hdmitx_i2s),
        .hdmitx_spdif_o  (hdmitx_spdif),
        .audmux_o        (audmux),
        .controls_o      (controls),
        .ext_io_o        (ext_io),
        .led_o           (led)
    );

    always #(CLK_PERIOD / 2) clk27 = ~clk27;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Upper LCG bits feed the audio pins and the IR line
    task automatic drive_random();
        lcg_state = lcg_next(lcg_state);
        pcm_i2s = lcg_state[18:16];
        hdmirx_i2s = lcg_state[21:19];
        hdmirx_ap = lcg_state[22];
        // External S/PDIF opposes the receiver pin so the source shows
        spdif_ext = ~lcg_state[22];
        ir_rx = lcg_state[24];
    endtask

    task automatic run_case(input int idx);
        int base;
        logic [2:0] i2s_exp;
        logic [2:0] led_exp;
        logic spdif_exp;
        logic [5:0] ext_exp;
        base = idx * FIELDS;
        @(posedge clk27);
        #2;
        sys_ctrl = case_mem[base][15:0];
        isl_video = case_mem[base + 1][26:0];
        hdmi_video = case_mem[base + 2][26:0];
        osd = case_mem[base + 3][2:0];
        btn = case_mem[base + 4][BTN_W-1:0];
        resync_strobe = case_mem[base + 5][0];
        drive_random();
        if (resync_strobe) begin
            hold_seen = 1'b1;
        end
        @(posedge clk27);
        #2 resync_strobe = 1'b0;
        repeat (CASE_CYCLES - 2) @(posedge clk27);
        @(negedge clk27);

        // Receiver group carries the audio packet pin as data
        if (sys_ctrl.capture_sel) begin
            i2s_exp = {hdmirx_i2s.bck, hdmirx_i2s.ws, hdmirx_ap};
        end else begin
            i2s_exp = pcm_i2s;
        end
        spdif_exp = sys_ctrl.hdmirx_spdif ? hdmirx_ap : spdif_ext;
        ext_exp = (btn == 6'h3F) ? 6'h3F : 6'h00;
        if (sys_ctrl.poweron) begin
            led_exp = {sys_ctrl.framelock, ~ir_rx, hold_seen};
        end else begin
            led_exp = LED_OFF_PATTERN;
        end

        check_value({5'b0, hdmitx_video}, case_mem[base + 6], "video output");
        check_value(controls, case_mem[base + 7], "controls word");
        check_value({26'b0, ext_io}, {26'b0, ext_exp}, "expansion port");
        check_value({29'b0, hdmitx_i2s}, {29'b0, i2s_exp}, "I2S output");
        check_value({31'b0, hdmitx_spdif}, {31'b0, spdif_exp}, "S/PDIF output");
        check_value({31'b0, audmux}, {31'b0, ~sys_ctrl.audmux_sel}, "audio mux select");
        check_value({29'b0, led}, {29'b0, led_exp}, "status LEDs");
    endtask

    initial begin
        clk27 = 1'b0;
        po_reset_n = 1'b0;
        sys_ctrl = '0;
        isl_video = '0;
        hdmi_video = '0;
        pcm_i2s = '0;
        hdmirx_i2s = '0;
        hdmirx_ap = 1'b0;
        spdif_ext = 1'b0;
        osd = '0;
        resync_strobe = 1'b0;
        btn = '1;
        ir_rx = 1'b1;
        lcg_state = 32'd10;
        hold_seen = 1'b0;
        checks = 0;
        errors = 0;
        $readmemh("tb/ossc_cases.txt", case_mem);
        repeat (RESET_CYCLES) @(posedge clk27);
        #2 po_reset_n = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the cases did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ossc_cases.txt ====
// ctrl isl_video hdmi_video osd btn strobe, then expected video and expected controls
// Video words are {r, g, b, hsync, vsync, de}; osd is {enable, color}
0001 091A2B5 55E6F7F 0 3F 0 091A2B5 003F0000
0101 091A2B5 55E6F7F 0 3F 0 091A2B1 003F0000
0201 091A2B5 55E6F7F 0 3E 0 091A2B7 003E0000
0301 091A2B5 55E6F7F 0 3F 0 091A2B3 003F0000
8081 091A2B5 55E6F7F 0 00 0 55E6F7F 00000000
4881 091A2B5 007F802 0 3F 0 007F802 003F0000
0001 091A2B5 55E6F7F 4 3F 0 0000005 003F0000
0001 091A2B5 55E6F7F 5 15 0 00007FD 00150000
0001 091A2B5 55E6F7F 6 3F 1 7FFF805 003F0000
4001 091A2B5 55E6F7F 7 3F 0 7FFFFFD 003F0000
0001 091A2B5 55E6F7F 3 3F 0 091A2B5 003F0000
0000 091A2B5 55E6F7F 0 3F 0 091A2B5 003F0000
8081 091A2B5 007F802 6 3F 0 7FFF802 003F0000

// ==== project.f ====
rtl/scan_pkg.sv
rtl/source_select.sv
rtl/panel_sync.sv
rtl/osd_overlay.sv
rtl/status_led.sv
rtl/ossc_top.sv
tb/ossc_sva.sv
tb/tb_ossc.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_ossc
FILELIST = project.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the log holds the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
